//--- cc_macros.svh
// Chitchat link constants shared by the TX and RX framers
`ifndef CC_MACROS_SVH
`define CC_MACROS_SVH

// --------------------------------------------------
// Identity of this end
// --------------------------------------------------
`define CC_REV_ID        32'hC0DE_0104
`define CC_GATEWARE_TYPE 3'd2
`define CC_PROTOCOL_VER  4'd1   // RX faults on anything else

// --------------------------------------------------
// Framing
// --------------------------------------------------
// Low byte is K28.5, high byte plain data, so k = 2'b01
`define CC_COMMA         16'h3CBC

`define CC_FRAME_WORDS   11     // Comma through CRC

// Words with no comma before the link counts as lost
`define CC_LOS_WORDS     64

`endif

//--- cc_pkg.sv
// Chitchat link types: header word layout, frame word views, fault bit positions
package cc_pkg;

   // --------------------------------------------------
   // Header word, frame word 1
   // --------------------------------------------------
   typedef struct packed {
      logic [3:0] protocol_ver;
      logic [2:0] gateware_type;
      logic [2:0] location;
      logic [5:0] reserved;   // Sent as zero
   } cc_hdr_t;

   // One 16-bit frame word seen either as raw data or as the header
   typedef union packed {
      logic [15:0] raw;
      cc_hdr_t     hdr;
   } cc_word_u;

   // --------------------------------------------------
   // Bit positions inside ccrx_fault
   // --------------------------------------------------
   typedef enum logic [1:0] {
      FAULT_CRC = 2'd0,   // CRC mismatch on word 10
      FAULT_LEN = 2'd1,   // Comma arrived mid-frame
      FAULT_VER = 2'd2    // Protocol version mismatch
   } cc_fault_e;

endpackage

//--- cc_link_if.sv
// Chitchat link bundles between the top-level wrapper and the TX/RX framers
`timescale 1ns/1ps

// --------------------------------------------------
// Wrapper to TX framer
// --------------------------------------------------
interface cc_tx_if;
   logic        transmit_en;
   logic [2:0]  location;
   logic [31:0] data0;
   logic [31:0] data1;
   logic [15:0] lback_counter;   // Last frame counter seen by RX
   logic [15:0] local_counter;   // Frame now on the wire

   modport tx (
      input  transmit_en, location, data0, data1, lback_counter,
      output local_counter
   );

   modport wrap (
      output transmit_en, location, data0, data1, lback_counter,
      input  local_counter
   );
endinterface

// --------------------------------------------------
// RX framer to wrapper
// --------------------------------------------------
interface cc_rx_if;
   logic        valid;
   logic        frame_drop;
   logic [31:0] data0;
   logic [31:0] data1;
   logic [15:0] frame_counter;
   logic [15:0] lback_counter;
   logic [3:0]  protocol_ver;
   logic [2:0]  gateware_type;
   logic [2:0]  location;
   logic [31:0] rev_id;
   logic [2:0]  fault;
   logic [15:0] fault_cnt;
   logic        los;

   modport rx (
      output valid, frame_drop, data0, data1, frame_counter, lback_counter,
      output protocol_ver, gateware_type, location, rev_id, fault, fault_cnt, los
   );

   modport wrap (
      input valid, frame_drop, data0, data1, frame_counter, lback_counter,
      input protocol_ver, gateware_type, location, rev_id, fault, fault_cnt, los
   );
endinterface

//--- cc_crc16.sv
// CRC-16-CCITT engine folding one 16-bit frame word per enabled cycle
`timescale 1ns/1ps

module cc_crc16 (
   input  logic        gtx_tx_clk,
   input  logic        i_clear,   // Frame start, wins over i_en
   input  logic        i_en,
   input  logic [15:0] i_word,
   output logic [15:0] o_crc
);

   localparam logic [15:0] POLY = 16'h1021;
   localparam logic [15:0] SEED = 16'hFFFF;

   logic [15:0] crc_q;

   // Bitwise fold, MSB of the word first
   function automatic logic [15:0] crc_fold(input logic [15:0] crc_in,
                                            input logic [15:0] word);
      logic [15:0] c;
      logic        fb;
      c = crc_in;
      for (int i = 15; i >= 0; i--) begin
         fb = c[15] ^ word[i];
         c  = {c[14:0], 1'b0} ^ (fb ? POLY : 16'h0000);
      end
      return c;
   endfunction

   always_ff @(posedge gtx_tx_clk) begin
      if (i_clear)
         crc_q <= SEED;
      else if (i_en)
         crc_q <= crc_fold(crc_q, i_word);
   end

   assign o_crc = crc_q;

endmodule

//--- cc_tx.sv
// Chitchat TX framer sending comma, header, payload, counters and CRC words
`timescale 1ns/1ps
`include "cc_macros.svh"

module cc_tx (
   input  logic        gtx_tx_clk,
   input  logic        i_rst,
   cc_tx_if.tx         tx,
   output logic [15:0] o_gtx_d,
   output logic [1:0]  o_gtx_k
);

   localparam logic [3:0]  LAST_IDX = 4'(`CC_FRAME_WORDS - 1);
   localparam logic [31:0] REV_ID   = `CC_REV_ID;

   logic [3:0]       idx;           // Word driven on the next edge
   logic [15:0]      local_cnt;
   logic [31:0]      data0_s;
   logic [31:0]      data1_s;
   logic [15:0]      crc;
   logic             frame_start;
   logic             crc_en;
   cc_pkg::cc_word_u next_w;
   logic [1:0]       next_k;

   assign frame_start = (idx == 4'd0) && tx.transmit_en;
   assign crc_en      = (idx != 4'd0) && (idx != LAST_IDX);   // Words 1 to 9

   // --------------------------------------------------
   // Next word on the wire
   // --------------------------------------------------
   always_comb begin
      next_w.raw = '0;
      next_k     = 2'b00;
      case (idx)
         4'd0: begin
            next_w.raw = `CC_COMMA;   // Also the idle fill
            next_k     = 2'b01;
         end
         4'd1: begin
            next_w.hdr.protocol_ver  = `CC_PROTOCOL_VER;
            next_w.hdr.gateware_type = `CC_GATEWARE_TYPE;
            next_w.hdr.location      = tx.location;
            next_w.hdr.reserved      = '0;
         end
         4'd2:    next_w.raw = REV_ID[31:16];
         4'd3:    next_w.raw = REV_ID[15:0];
         4'd4:    next_w.raw = data0_s[31:16];
         4'd5:    next_w.raw = data0_s[15:0];
         4'd6:    next_w.raw = data1_s[31:16];
         4'd7:    next_w.raw = data1_s[15:0];
         4'd8:    next_w.raw = local_cnt;
         4'd9:    next_w.raw = tx.lback_counter;   // Live value, freshest echo
         default: next_w.raw = crc;                // Word 10
      endcase
   end

   // --------------------------------------------------
   // Sequencer and output register
   // --------------------------------------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (i_rst) begin
         idx       <= '0;
         local_cnt <= '0;
         o_gtx_d   <= `CC_COMMA;
         o_gtx_k   <= 2'b01;
      end else begin
         o_gtx_d <= next_w.raw;
         o_gtx_k <= next_k;
         if (idx == 4'd0) begin
            if (tx.transmit_en) begin   // Otherwise keep sending commas
               idx       <= 4'd1;
               local_cnt <= local_cnt + 16'd1;
            end
         end else if (idx == LAST_IDX) begin
            idx <= '0;
         end else begin
            idx <= idx + 4'd1;
         end
      end
   end

   // Payload frozen for the whole frame
   always_ff @(posedge gtx_tx_clk) begin
      if (frame_start) begin
         data0_s <= tx.data0;
         data1_s <= tx.data1;
      end
   end

   cc_crc16 u_crc (
      .gtx_tx_clk (gtx_tx_clk),
      .i_clear    (frame_start),
      .i_en       (crc_en),
      .i_word     (next_w.raw),
      .o_crc      (crc)
   );

   assign tx.local_counter = local_cnt;

endmodule

//--- cc_rx.sv
// Chitchat RX framer with comma alignment, frame checks and loss-of-signal watchdog
`timescale 1ns/1ps
`include "cc_macros.svh"

module cc_rx (
   input  logic        gtx_tx_clk,
   input  logic        i_rst,
   input  logic [15:0] i_gtx_d,
   input  logic [1:0]  i_gtx_k,
   cc_rx_if.rx         rx
);

   localparam logic [3:0]       LAST_IDX = 4'(`CC_FRAME_WORDS - 1);
   localparam int               LOS_W    = $clog2(`CC_LOS_WORDS + 1);
   localparam logic [LOS_W-1:0] LOS_LAST = LOS_W'(`CC_LOS_WORDS - 1);

   cc_pkg::cc_word_u d_r;
   logic [1:0]       k_r;
   logic             is_comma;
   logic [3:0]       nidx;          // Index of the word in d_r, 0 when unaligned
   logic             in_body;
   logic             frame_end;
   logic             truncated;
   logic [15:0]      crc;
   logic             crc_bad;
   logic [2:0]       fault_n;
   logic             good;
   logic             bad;
   logic [15:0]      fault_cnt_q;
   logic [LOS_W-1:0] los_cnt;

   // Frame fields collected word by word
   cc_pkg::cc_hdr_t  hdr_s;
   logic             ver_bad_s;
   logic [31:0]      rev_s;
   logic [31:0]      d0_s;
   logic [31:0]      d1_s;
   logic [15:0]      fc_s;
   logic [15:0]      lb_s;

   always_ff @(posedge gtx_tx_clk) begin
      if (i_rst) begin
         d_r.raw <= '0;
         k_r     <= '0;
      end else begin
         d_r.raw <= i_gtx_d;
         k_r     <= i_gtx_k;
      end
   end

   assign is_comma  = (k_r == 2'b01) && (d_r.raw == `CC_COMMA);
   assign in_body   = !is_comma && (nidx != 4'd0) && (nidx != LAST_IDX);
   assign frame_end = !is_comma && (nidx == LAST_IDX);
   assign truncated = is_comma && (nidx > 4'd1);   // Header seen, frame cut short
   assign crc_bad   = (crc != d_r.raw);

   always_comb begin
      fault_n                    = '0;
      fault_n[cc_pkg::FAULT_CRC] = frame_end && crc_bad;
      fault_n[cc_pkg::FAULT_LEN] = truncated;
      fault_n[cc_pkg::FAULT_VER] = (frame_end || truncated) && ver_bad_s;
   end

   assign good = frame_end && (fault_n == '0);
   assign bad  = (fault_n != '0);

   // --------------------------------------------------
   // Word alignment
   // --------------------------------------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (i_rst)
         nidx <= '0;
      else if (is_comma)
         nidx <= 4'd1;
      else if (nidx == LAST_IDX)
         nidx <= '0;   // Wait for the next comma
      else if (nidx != 4'd0)
         nidx <= nidx + 4'd1;
   end

   always_ff @(posedge gtx_tx_clk) begin
      if (!is_comma) begin
         case (nidx)
            4'd1: begin
               hdr_s     <= d_r.hdr;
               ver_bad_s <= (d_r.hdr.protocol_ver != `CC_PROTOCOL_VER);
            end
            4'd2:    rev_s[31:16] <= d_r.raw;
            4'd3:    rev_s[15:0]  <= d_r.raw;
            4'd4:    d0_s[31:16]  <= d_r.raw;
            4'd5:    d0_s[15:0]   <= d_r.raw;
            4'd6:    d1_s[31:16]  <= d_r.raw;
            4'd7:    d1_s[15:0]   <= d_r.raw;
            4'd8:    fc_s         <= d_r.raw;
            4'd9:    lb_s         <= d_r.raw;
            default: ;
         endcase
      end
   end

   cc_crc16 u_crc (
      .gtx_tx_clk (gtx_tx_clk),
      .i_clear    (is_comma),
      .i_en       (in_body),
      .i_word     (d_r.raw),
      .o_crc      (crc)
   );

   // --------------------------------------------------
   // Frame result
   // --------------------------------------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (i_rst) begin
         rx.valid         <= 1'b0;
         rx.frame_drop    <= 1'b0;
         rx.fault         <= '0;
         rx.frame_counter <= '0;
         rx.lback_counter <= '0;
         fault_cnt_q      <= '0;
      end else begin
         rx.valid      <= good;   // One-cycle pulses
         rx.frame_drop <= bad;
         if (frame_end || truncated)
            rx.fault <= fault_n;
         if (bad)
            fault_cnt_q <= fault_cnt_q + 16'd1;
         if (good) begin
            rx.frame_counter <= fc_s;
            rx.lback_counter <= lb_s;
         end
      end
   end

   always_ff @(posedge gtx_tx_clk) begin
      if (good) begin
         rx.data0         <= d0_s;
         rx.data1         <= d1_s;
         rx.rev_id        <= rev_s;
         rx.protocol_ver  <= hdr_s.protocol_ver;
         rx.gateware_type <= hdr_s.gateware_type;
         rx.location      <= hdr_s.location;
      end
   end

   assign rx.fault_cnt = fault_cnt_q;

   // --------------------------------------------------
   // Loss of signal
   // --------------------------------------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (i_rst) begin
         los_cnt <= '0;
         rx.los  <= 1'b1;   // Lost until a good frame proves otherwise
      end else begin
         if (is_comma)
            los_cnt <= '0;
         else if (los_cnt != LOS_LAST)
            los_cnt <= los_cnt + 1'b1;
         if (good)
            rx.los <= 1'b0;
         else if (!is_comma && los_cnt == LOS_LAST)
            rx.los <= 1'b1;
      end
   end

endmodule

//--- cc_txrx_wrap.sv
// Chitchat link top joining TX and RX framers, with payload latches and loop latency
`timescale 1ns/1ps

module cc_txrx_wrap (
   input  logic        gtx_tx_clk,
   input  logic        i_rst,

   input  logic        i_tx_transmit_en,
   input  logic [2:0]  i_tx_location,
   input  logic        i_tx_valid0,
   input  logic        i_tx_valid1,
   input  logic [31:0] i_tx_data0,
   input  logic [31:0] i_tx_data1,

   input  logic [15:0] i_gtx_rx_d,
   input  logic [1:0]  i_gtx_rx_k,
   output logic [15:0] o_gtx_tx_d,
   output logic [1:0]  o_gtx_tx_k,

   output logic        o_rx_valid,
   output logic        o_ccrx_frame_drop,
   output logic [31:0] o_rx_data0,
   output logic [31:0] o_rx_data1,
   output logic [15:0] o_rx_frame_counter,
   output logic [3:0]  o_rx_protocol_ver,
   output logic [2:0]  o_rx_gateware_type,
   output logic [2:0]  o_rx_location,
   output logic [31:0] o_rx_rev_id,
   output logic [2:0]  o_ccrx_fault,
   output logic [15:0] o_ccrx_fault_cnt,
   output logic        o_ccrx_los,
   output logic [15:0] o_txrx_latency
);

   cc_tx_if tx_if ();
   cc_rx_if rx_if ();

   logic [31:0] tx_data0_q;
   logic [31:0] tx_data1_q;
   logic        tx_en_q;
   logic [2:0]  tx_loc_q;
   logic [15:0] latency_q;

   // --------------------------------------------------
   // TX side
   // --------------------------------------------------
   // A newer strobe before frame start overwrites the older word
   always_ff @(posedge gtx_tx_clk) begin
      if (i_tx_valid0)
         tx_data0_q <= i_tx_data0;
      if (i_tx_valid1)
         tx_data1_q <= i_tx_data1;
   end

   always_ff @(posedge gtx_tx_clk) begin
      if (i_rst) begin
         tx_en_q  <= 1'b0;
         tx_loc_q <= '0;
      end else begin
         tx_en_q  <= i_tx_transmit_en;
         tx_loc_q <= i_tx_location;
      end
   end

   assign tx_if.transmit_en   = tx_en_q;
   assign tx_if.location      = tx_loc_q;
   assign tx_if.data0         = tx_data0_q;
   assign tx_if.data1         = tx_data1_q;
   assign tx_if.lback_counter = rx_if.frame_counter;   // Echo to far end

   cc_tx u_tx (
      .gtx_tx_clk (gtx_tx_clk),
      .i_rst      (i_rst),
      .tx         (tx_if.tx),
      .o_gtx_d    (o_gtx_tx_d),
      .o_gtx_k    (o_gtx_tx_k)
   );

   // --------------------------------------------------
   // RX side
   // --------------------------------------------------
   cc_rx u_rx (
      .gtx_tx_clk (gtx_tx_clk),
      .i_rst      (i_rst),
      .i_gtx_d    (i_gtx_rx_d),
      .i_gtx_k    (i_gtx_rx_k),
      .rx         (rx_if.rx)
   );

   // Round trip in frames, from our own counter echoed back
   always_ff @(posedge gtx_tx_clk) begin
      if (i_rst)
         latency_q <= '0;
      else if (rx_if.valid)
         latency_q <= tx_if.local_counter - rx_if.lback_counter;
   end

   // Good frames and drops leave on separate strobes
   assign o_rx_valid         = rx_if.valid;
   assign o_ccrx_frame_drop  = rx_if.frame_drop;
   assign o_rx_data0         = rx_if.data0;
   assign o_rx_data1         = rx_if.data1;
   assign o_rx_frame_counter = rx_if.frame_counter;
   assign o_rx_protocol_ver  = rx_if.protocol_ver;
   assign o_rx_gateware_type = rx_if.gateware_type;
   assign o_rx_location      = rx_if.location;
   assign o_rx_rev_id        = rx_if.rev_id;
   assign o_ccrx_fault       = rx_if.fault;
   assign o_ccrx_fault_cnt   = rx_if.fault_cnt;
   assign o_ccrx_los         = rx_if.los;
   assign o_txrx_latency     = latency_q;

endmodule

//--- cc_txrx_chk.sv
// Protocol checks on the chitchat link top-level ports
`timescale 1ns/1ps

module cc_txrx_chk (
   input logic       gtx_tx_clk,
   input logic       i_rst,
   input logic       i_rx_valid,
   input logic       i_frame_drop,
   input logic [1:0] i_tx_k,
   input logic [2:0] i_fault
);

   // Good frame and drop are exclusive
   a_valid_drop: assert property (@(posedge gtx_tx_clk) disable iff (i_rst)
      !(i_rx_valid && i_frame_drop))
      else $error("o_rx_valid and o_ccrx_frame_drop high together");

   // Only the comma carries a K flag, on the low byte
   a_tx_k: assert property (@(posedge gtx_tx_clk) disable iff (i_rst)
      (i_tx_k == 2'b00) || (i_tx_k == 2'b01))
      else $error("o_gtx_tx_k outside 00 and 01");

   a_clean_valid: assert property (@(posedge gtx_tx_clk) disable iff (i_rst)
      i_rx_valid |-> (i_fault == 3'b000))
      else $error("o_ccrx_fault nonzero on o_rx_valid");

endmodule

bind cc_txrx_wrap cc_txrx_chk u_chk (
   .gtx_tx_clk   (gtx_tx_clk),
   .i_rst        (i_rst),
   .i_rx_valid   (o_rx_valid),
   .i_frame_drop (o_ccrx_frame_drop),
   .i_tx_k       (o_gtx_tx_k),
   .i_fault      (o_ccrx_fault)
);

//--- tb_cc_txrx.sv
// Loopback testbench for the chitchat link top with CRC and signal-loss injection
`timescale 1ns/1ps
`include "cc_macros.svh"

module tb_cc_txrx;

   localparam int N_ROWS  = 7;
   localparam int TIMEOUT = 100;   // Cycles per wait

   typedef struct packed {
      logic [31:0] data0;
      logic [31:0] data1;
      logic [2:0]  loc;
      logic        corrupt;     // Flip one bit of word 4
      logic        cut;         // Hold the loopback at zero first
      logic        exp_drop;
      logic [2:0]  exp_fault;
   } row_t;

   logic        gtx_tx_clk = 1'b0;
   logic        i_rst;
   logic        i_tx_transmit_en;
   logic [2:0]  i_tx_location;
   logic        i_tx_valid0;
   logic        i_tx_valid1;
   logic [31:0] i_tx_data0;
   logic [31:0] i_tx_data1;
   logic [15:0] i_gtx_rx_d;
   logic [1:0]  i_gtx_rx_k;
   logic [15:0] o_gtx_tx_d;
   logic [1:0]  o_gtx_tx_k;
   logic        o_rx_valid;
   logic        o_ccrx_frame_drop;
   logic [31:0] o_rx_data0;
   logic [31:0] o_rx_data1;
   logic [15:0] o_rx_frame_counter;
   logic [3:0]  o_rx_protocol_ver;
   logic [2:0]  o_rx_gateware_type;
   logic [2:0]  o_rx_location;
   logic [31:0] o_rx_rev_id;
   logic [2:0]  o_ccrx_fault;
   logic [15:0] o_ccrx_fault_cnt;
   logic        o_ccrx_los;
   logic [15:0] o_txrx_latency;

   logic [15:0] mask      = '0;
   logic [3:0]  tx_pos    = '0;   // Index of the word now on the TX wire
   logic [15:0] tx_frames = '0;   // Frames whose header has left TX
   logic        cut;
   logic        corrupt_on;
   logic [31:0] rng;
   logic [15:0] exp_cnt;
   logic [15:0] exp_fc;
   row_t        rows [N_ROWS];

   always #50 gtx_tx_clk = ~gtx_tx_clk;

   // External loopback with fault injection
   assign i_gtx_rx_d = cut ? 16'h0000 : (o_gtx_tx_d ^ mask);
   assign i_gtx_rx_k = cut ? 2'b00 : o_gtx_tx_k;

   cc_txrx_wrap u_dut (
      .gtx_tx_clk         (gtx_tx_clk),
      .i_rst              (i_rst),
      .i_tx_transmit_en   (i_tx_transmit_en),
      .i_tx_location      (i_tx_location),
      .i_tx_valid0        (i_tx_valid0),
      .i_tx_valid1        (i_tx_valid1),
      .i_tx_data0         (i_tx_data0),
      .i_tx_data1         (i_tx_data1),
      .i_gtx_rx_d         (i_gtx_rx_d),
      .i_gtx_rx_k         (i_gtx_rx_k),
      .o_gtx_tx_d         (o_gtx_tx_d),
      .o_gtx_tx_k         (o_gtx_tx_k),
      .o_rx_valid         (o_rx_valid),
      .o_ccrx_frame_drop  (o_ccrx_frame_drop),
      .o_rx_data0         (o_rx_data0),
      .o_rx_data1         (o_rx_data1),
      .o_rx_frame_counter (o_rx_frame_counter),
      .o_rx_protocol_ver  (o_rx_protocol_ver),
      .o_rx_gateware_type (o_rx_gateware_type),
      .o_rx_location      (o_rx_location),
      .o_rx_rev_id        (o_rx_rev_id),
      .o_ccrx_fault       (o_ccrx_fault),
      .o_ccrx_fault_cnt   (o_ccrx_fault_cnt),
      .o_ccrx_los         (o_ccrx_los),
      .o_txrx_latency     (o_txrx_latency)
   );

   // --------------------------------------------------
   // TX word tracker and corruption mask
   // --------------------------------------------------
   always @(posedge gtx_tx_clk) begin
      logic [3:0] npos;
      logic       tx_comma;
      tx_comma = (o_gtx_tx_k == 2'b01) && (o_gtx_tx_d == `CC_COMMA);
      if (tx_comma)
         npos = 4'd1;            // Header follows a comma
      else if (tx_pos == 4'd10)
         npos = 4'd0;
      else
         npos = tx_pos + 4'd1;
      if (i_rst) begin
         tx_pos    <= '0;
         mask      <= '0;
         tx_frames <= '0;
      end else begin
         tx_pos <= npos;
         mask   <= (corrupt_on && npos == 4'd4) ? 16'h0100 : 16'h0000;
         if (tx_pos == 4'd1 && !tx_comma)
            tx_frames <= tx_frames + 16'd1;   // Header on the wire
      end
   end

   // --------------------------------------------------
   // Helpers
   // --------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic stop_with_failure();
      $display("Test FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic add_row(input int idx, input logic [2:0] loc, input logic corrupt,
                          input logic cut_en, input logic exp_drop,
                          input logic [2:0] exp_fault);
      rng = xorshift32(rng);
      rows[idx].data0 = rng;
      rng = xorshift32(rng);
      rows[idx].data1     = rng;
      rows[idx].loc       = loc;
      rows[idx].corrupt   = corrupt;
      rows[idx].cut       = cut_en;
      rows[idx].exp_drop  = exp_drop;
      rows[idx].exp_fault = exp_fault;
   endtask

   task automatic send_payload(input int idx);
      @(posedge gtx_tx_clk);
      i_tx_valid0   <= 1'b1;
      i_tx_valid1   <= 1'b1;
      i_tx_data0    <= rows[idx].data0;
      i_tx_data1    <= rows[idx].data1;
      i_tx_location <= rows[idx].loc;
      @(posedge gtx_tx_clk);
      i_tx_valid0 <= 1'b0;
      i_tx_valid1 <= 1'b0;
   endtask

   // Word 0 of the first frame that loaded the new payload
   task automatic wait_comma();
      logic seen;
      seen = 1'b0;
      @(negedge gtx_tx_clk);   // Loaded before the latch updated
      for (int i = 0; i < TIMEOUT && !seen; i++) begin
         @(negedge gtx_tx_clk);
         seen = (o_gtx_tx_k == 2'b01) && (o_gtx_tx_d == `CC_COMMA);
      end
      if (!seen) begin
         $display("Timeout while waiting for a comma on the TX output");
         stop_with_failure();
      end
   endtask

   task automatic wait_result(input logic want_drop);
      logic seen;
      seen = 1'b0;
      for (int i = 0; i < TIMEOUT && !seen; i++) begin
         @(negedge gtx_tx_clk);
         seen = o_rx_valid || o_ccrx_frame_drop;
      end
      if (!seen) begin
         $display("Timeout while waiting for o_rx_valid or o_ccrx_frame_drop");
         stop_with_failure();
      end else if (want_drop && o_rx_valid) begin
         $display("A corrupted frame was delivered instead of dropped");
         stop_with_failure();
      end else if (!want_drop && o_ccrx_frame_drop) begin
         $display("A clean frame was dropped");
         stop_with_failure();
      end
   endtask

   // Cut the loopback at a frame boundary so no partial frame is seen
   task automatic cut_link();
      logic seen;
      seen = 1'b0;
      for (int i = 0; i < TIMEOUT && !seen; i++) begin
         @(negedge gtx_tx_clk);
         seen = (tx_pos == 4'd10) && (o_gtx_tx_k == 2'b00);
      end
      if (!seen) begin
         $display("Timeout while waiting for a CRC word on the TX output");
         stop_with_failure();
      end
      check_value("o_ccrx_los", 32'(o_ccrx_los), 32'h0);
      @(posedge gtx_tx_clk);
      cut <= 1'b1;
      repeat (79) @(posedge gtx_tx_clk);
      @(negedge gtx_tx_clk);
      check_value("o_ccrx_los", 32'(o_ccrx_los), 32'h1);
      @(posedge gtx_tx_clk);
      cut <= 1'b0;
      wait_result(1'b0);
      check_value("o_ccrx_los", 32'(o_ccrx_los), 32'h0);
   endtask

   // --------------------------------------------------
   // Stimulus
   // --------------------------------------------------
   initial begin
      i_rst            = 1'b1;
      i_tx_transmit_en = 1'b0;
      i_tx_location    = '0;
      i_tx_valid0      = 1'b1;   // Clears the payload latches during reset
      i_tx_valid1      = 1'b1;
      i_tx_data0       = '0;
      i_tx_data1       = '0;
      cut              = 1'b0;
      corrupt_on       = 1'b0;
      exp_cnt          = '0;
      exp_fc           = '0;
      rng              = 32'h28db91fc;

      //      row loc   corrupt cut   drop  fault
      add_row(0, 3'd5, 1'b0, 1'b0, 1'b0, 3'b000);
      add_row(1, 3'd2, 1'b0, 1'b0, 1'b0, 3'b000);
      add_row(2, 3'd3, 1'b1, 1'b0, 1'b1, 3'b001);
      add_row(3, 3'd6, 1'b0, 1'b0, 1'b0, 3'b000);
      add_row(4, 3'd1, 1'b0, 1'b1, 1'b0, 3'b000);
      add_row(5, 3'd7, 1'b0, 1'b0, 1'b0, 3'b000);
      add_row(6, 3'd0, 1'b0, 1'b0, 1'b0, 3'b000);

      repeat (2) @(posedge gtx_tx_clk);
      i_rst       <= 1'b0;
      i_tx_valid0 <= 1'b0;
      i_tx_valid1 <= 1'b0;
      @(negedge gtx_tx_clk);
      check_value("o_rx_valid", 32'(o_rx_valid), 32'h0);
      check_value("o_ccrx_fault_cnt", 32'(o_ccrx_fault_cnt), 32'h0);
      check_value("o_txrx_latency", 32'(o_txrx_latency), 32'h0);
      check_value("o_ccrx_los", 32'(o_ccrx_los), 32'h1);
      check_value("o_gtx_tx_d", 32'(o_gtx_tx_d), 32'(`CC_COMMA));   // Idle fill
      check_value("o_gtx_tx_k", 32'(o_gtx_tx_k), 32'h1);
      @(posedge gtx_tx_clk);
      i_tx_transmit_en <= 1'b1;

      for (int r = 0; r < N_ROWS; r++) begin
         if (rows[r].cut)
            cut_link();
         send_payload(r);
         wait_comma();
         exp_fc = tx_frames + 16'd1;      // Number of the frame just started
         @(posedge gtx_tx_clk);
         corrupt_on <= rows[r].corrupt;   // Hits word 4 of this frame
         @(negedge gtx_tx_clk);           // Result of the frame before
         if (rows[r].exp_drop) begin
            exp_cnt = exp_cnt + 16'd1;
            wait_result(1'b1);
            check_value("o_ccrx_fault", 32'(o_ccrx_fault), 32'(rows[r].exp_fault));
            check_value("o_ccrx_fault_cnt", 32'(o_ccrx_fault_cnt), 32'(exp_cnt));
            @(posedge gtx_tx_clk);
            corrupt_on <= 1'b0;
         end else begin
            wait_result(1'b0);
            check_value("o_rx_data0", o_rx_data0, rows[r].data0);
            check_value("o_rx_data1", o_rx_data1, rows[r].data1);
            check_value("o_rx_location", 32'(o_rx_location), 32'(rows[r].loc));
            check_value("o_rx_protocol_ver", 32'(o_rx_protocol_ver),
                        32'(`CC_PROTOCOL_VER));
            check_value("o_rx_gateware_type", 32'(o_rx_gateware_type),
                        32'(`CC_GATEWARE_TYPE));
            check_value("o_rx_rev_id", o_rx_rev_id, `CC_REV_ID);
            check_value("o_ccrx_fault", 32'(o_ccrx_fault), 32'(rows[r].exp_fault));
            check_value("o_ccrx_fault_cnt", 32'(o_ccrx_fault_cnt), 32'(exp_cnt));
            check_value("o_ccrx_los", 32'(o_ccrx_los), 32'h0);
            check_value("o_rx_frame_counter", 32'(o_rx_frame_counter), 32'(exp_fc));
            wait_result(1'b0);
            check_value("o_rx_frame_counter", 32'(o_rx_frame_counter),
                        32'(exp_fc + 16'd1));
            @(negedge gtx_tx_clk);   // Latency lands one cycle later
            check_value("o_txrx_latency", 32'(o_txrx_latency), 32'h2);
         end
      end

      $display("Test OK");
      $finish;
   end

endmodule

//--- files.f
+incdir+.
cc_pkg.sv
cc_link_if.sv
cc_crc16.sv
cc_tx.sv
cc_rx.sv
cc_txrx_wrap.sv
cc_txrx_chk.sv
tb_cc_txrx.sv

//--- run.sh
#!/bin/sh
# Build the chitchat link testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_cc_txrx -f files.f

out=$(./obj_dir/Vtb_cc_txrx 2>&1) || true
printf '%s\n' "$out"

# Pass only if the testbench printed its pass line
printf '%s\n' "$out" | grep -qx 'Test OK'
